// ==== project.f ====
+incdir+.
arch_pkg.sv
rename_pkg.sv
rename_skid_buffer.sv
rename_map_table.sv
rename_free_list.sv
rename_logic.sv
rename_stage.sv
tb_rename_stage.sv

// ==== Makefile ====
.PHONY: simulate clean

simulate:
	verilator --binary --timing -f project.f --top-module tb_rename_stage -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_rename_stage.sv ====
`timescale 1ns/10ps

module tb_rename_stage;

    typedef struct packed {
        rename_pkg::bundle_t bundle;
        rename_pkg::commit_t commit;
        rename_pkg::packet_t expected;
    } row_t;

    logic                cpu_clock = 1'b0;
    logic                reset;
    rename_pkg::bundle_t bundle;
    logic                bundle_valid;
    logic                bundle_ready;
    rename_pkg::packet_t packet;
    logic                packet_valid;
    logic                packet_ready;
    rename_pkg::commit_t commit;

    row_t                rows [$];
    string               names [$];
    int                  received = 0;
    int                  cycle_count = 0;
    int                  cycle_limit = 0;
    logic [31:0]         rng_state = 32'd15;
    logic                holding = 1'b0;
    rename_pkg::packet_t held;

    rename_stage i_rename_stage (
        .reset_i        (reset),
        .cpu_clock_i    (cpu_clock),
        .bundle_i       (bundle),
        .bundle_valid_i (bundle_valid),
        .bundle_ready_o (bundle_ready),
        .packet_o       (packet),
        .packet_valid_o (packet_valid),
        .packet_ready_i (packet_ready),
        .commit_i       (commit)
    );

    always #5 cpu_clock = ~cpu_clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic arch_pkg::instr_t make_instr(input int valid, input arch_pkg::opcode_e op,
                                                    input int rs1, input int rs2, input int rd,
                                                    input int writes_rd);
        arch_pkg::instr_t ins;
        ins.valid     = (valid != 0);
        ins.opcode    = op;
        ins.rs1       = arch_pkg::areg_t'(rs1);
        ins.rs2       = arch_pkg::areg_t'(rs2);
        ins.rd        = arch_pkg::areg_t'(rd);
        ins.writes_rd = (writes_rd != 0);
        return ins;
    endfunction

    function automatic rename_pkg::renamed_t make_renamed(input int valid,
                                                          input arch_pkg::opcode_e op,
                                                          input int prs1, input int prs2,
                                                          input int pdest, input int old_pdest);
        rename_pkg::renamed_t r;
        r.valid     = (valid != 0);
        r.opcode    = op;
        r.prs1      = rename_pkg::preg_t'(prs1);
        r.prs2      = rename_pkg::preg_t'(prs2);
        r.pdest     = rename_pkg::preg_t'(pdest);
        r.old_pdest = rename_pkg::preg_t'(old_pdest);
        r.allocated = (pdest != 0); // register 0 never enters the free list
        return r;
    endfunction

    task automatic add_row(input string name, input arch_pkg::instr_t i0,
                           input arch_pkg::instr_t i1, input int commit_preg,
                           input rename_pkg::renamed_t e0, input rename_pkg::renamed_t e1);
        row_t row;
        row.bundle.ins0   = i0;
        row.bundle.ins1   = i1;
        row.commit        = '0;
        if (commit_preg >= 0) begin
            row.commit.valid = 1'b1;
            row.commit.preg  = rename_pkg::preg_t'(commit_preg);
        end
        row.expected.ins0 = e0;
        row.expected.ins1 = e1;
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic build_table();
        int fresh [$];
        for (int r = 4; r < 32; r++) begin
            if (r != 7) fresh.push_back(r); // registers no earlier row has renamed
        end
        add_row("first_bundle", make_instr(1, arch_pkg::OP_ADD, 3, 4, 1, 1),
                make_instr(1, arch_pkg::OP_SUB, 5, 6, 2, 1), -1,
                make_renamed(1, arch_pkg::OP_ADD, 3, 4, 32, 1),
                make_renamed(1, arch_pkg::OP_SUB, 5, 6, 33, 2));
        // ins1 reads and rewrites r7, which ins0 writes in the same bundle
        add_row("intra_bypass", make_instr(1, arch_pkg::OP_AND, 1, 2, 7, 1),
                make_instr(1, arch_pkg::OP_OR, 7, 1, 7, 1), -1,
                make_renamed(1, arch_pkg::OP_AND, 32, 33, 34, 7),
                make_renamed(1, arch_pkg::OP_OR, 34, 32, 35, 34));
        add_row("no_dest", make_instr(1, arch_pkg::OP_STORE, 7, 1, 9, 0),
                make_instr(1, arch_pkg::OP_ADD, 2, 0, 0, 1), -1,
                make_renamed(1, arch_pkg::OP_STORE, 35, 32, 0, 0),
                make_renamed(1, arch_pkg::OP_ADD, 33, 0, 0, 0));
        // ins1 names a destination, only its cleared valid bit keeps it from allocating
        add_row("single_ins", make_instr(1, arch_pkg::OP_LOAD, 2, 0, 3, 1),
                make_instr(0, arch_pkg::OP_ADD, 0, 0, 10, 1), -1,
                make_renamed(1, arch_pkg::OP_LOAD, 33, 0, 36, 3), '0);
        // drain the rest of the free list, registers 37 to 63 in order
        for (int k = 0; k < fresh.size(); k += 2) begin
            if (k + 1 < fresh.size()) begin
                add_row($sformatf("drain_r%0d", fresh[k]),
                        make_instr(1, arch_pkg::OP_XOR, 0, 0, fresh[k], 1),
                        make_instr(1, arch_pkg::OP_ADD, 0, 0, fresh[k+1], 1), -1,
                        make_renamed(1, arch_pkg::OP_XOR, 0, 0, 37 + k, fresh[k]),
                        make_renamed(1, arch_pkg::OP_ADD, 0, 0, 38 + k, fresh[k+1]));
            end else begin
                add_row($sformatf("drain_r%0d", fresh[k]),
                        make_instr(1, arch_pkg::OP_XOR, 0, 0, fresh[k], 1), '0, -1,
                        make_renamed(1, arch_pkg::OP_XOR, 0, 0, 37 + k, fresh[k]), '0);
            end
        end
        // the free list is empty here, so this one waits for the first commit
        add_row("starved", make_instr(1, arch_pkg::OP_ADD, 1, 0, 1, 1), '0, -1,
                make_renamed(1, arch_pkg::OP_ADD, 32, 0, 1, 32), '0);
        add_row("commit_1", make_instr(1, arch_pkg::OP_OR, 2, 3, 0, 0), '0, 1,
                make_renamed(1, arch_pkg::OP_OR, 33, 36, 0, 0), '0);
        add_row("commit_2", make_instr(1, arch_pkg::OP_ADD, 1, 0, 2, 1),
                make_instr(1, arch_pkg::OP_XOR, 2, 2, 3, 1), 2,
                make_renamed(1, arch_pkg::OP_ADD, 1, 0, 2, 33),
                make_renamed(1, arch_pkg::OP_XOR, 2, 2, 3, 36));
        add_row("commit_3", make_instr(1, arch_pkg::OP_SHIFT, 3, 4, 4, 1), '0, 3,
                make_renamed(1, arch_pkg::OP_SHIFT, 3, 37, 4, 37), '0);
        add_row("commit_4", make_instr(1, arch_pkg::OP_STORE, 4, 1, 0, 0), '0, 4,
                make_renamed(1, arch_pkg::OP_STORE, 4, 1, 0, 0), '0);
        add_row("commit_5", make_instr(1, arch_pkg::OP_ADD, 5, 2, 5, 1), '0, 5,
                make_renamed(1, arch_pkg::OP_ADD, 38, 2, 5, 38), '0);
    endtask

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input string name, input rename_pkg::packet_t expected,
                         input rename_pkg::packet_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // ready to the issue side drops on random cycles
    always @(posedge cpu_clock) begin
        #1;
        rng_state    = lcg_next(rng_state);
        packet_ready = (rng_state[17:16] != 2'b00);
    end

    // sampled mid-cycle where every registered output has settled
    always @(negedge cpu_clock) begin
        if (!reset && packet_valid) begin
            if (received >= rows.size()) begin
                $display("a packet arrived after the last table row was checked");
                abort_run();
            end
            if (holding) check(names[received], held, packet);
            if (packet_ready) begin
                check(names[received], rows[received].expected, packet);
                received++;
                holding = 1'b0;
            end else begin
                holding = 1'b1;
                held    = packet;
            end
        end else begin
            if (holding) begin
                $display("packet_valid dropped before the stalled packet was taken");
                abort_run();
            end
            holding = 1'b0;
        end
    end

    always @(posedge cpu_clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d packets seen", cycle_count, received);
            abort_run();
        end
    end

    initial begin
        logic ready_seen;
        reset        = 1'b1;
        bundle       = '0;
        bundle_valid = 1'b0;
        packet_ready = 1'b0;
        commit       = '0;
        build_table();
        cycle_limit = 16 + 32 + 8 * rows.size();
        repeat (16) @(posedge cpu_clock);
        #1;
        reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            bundle       = rows[i].bundle;
            bundle_valid = 1'b1;
            commit       = rows[i].commit; // one cycle only, whether or not the bundle moves
            ready_seen   = 1'b0;
            while (!ready_seen) begin
                ready_seen = bundle_ready;
                @(posedge cpu_clock);
                #1;
                commit = '0;
            end
        end
        bundle_valid = 1'b0;
        bundle       = '0;
        while (received < rows.size()) @(posedge cpu_clock);
        repeat (20) @(posedge cpu_clock);
        if (received == rows.size()) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("expected %0d packets but saw %0d", rows.size(), received);
            abort_run();
        end
    end

endmodule

// ==== rename_stage.sv ====
`timescale 1ns/10ps
`include "rename_params.svh"

module rename_stage (
    input  logic                reset_i,
    input  logic                cpu_clock_i,
    input  rename_pkg::bundle_t bundle_i,
    input  logic                bundle_valid_i,
    output logic                bundle_ready_o,
    output rename_pkg::packet_t packet_o,
    output logic                packet_valid_o,
    input  logic                packet_ready_i,
    input  rename_pkg::commit_t commit_i
);

    rename_pkg::bundle_t         skid_bundle;
    logic                        skid_valid;
    logic                        skid_ready;
    arch_pkg::areg_t       [5:0] map_rd_idx;
    rename_pkg::preg_t     [5:0] map_rd_preg;
    logic                  [1:0] map_wr_en;
    arch_pkg::areg_t       [1:0] map_wr_idx;
    rename_pkg::preg_t     [1:0] map_wr_preg;
    rename_pkg::preg_t           free_head0;
    rename_pkg::preg_t           free_head1;
    logic [`RN_PREG_W-1:0]       free_count;
    logic                        pop0;
    logic                        pop1;

    rename_skid_buffer i_skid_buffer (
        .reset_i     (reset_i),
        .cpu_clock_i (cpu_clock_i),
        .in_i        (bundle_i),
        .in_valid_i  (bundle_valid_i),
        .in_ready_o  (bundle_ready_o),
        .out_o       (skid_bundle),
        .out_valid_o (skid_valid),
        .out_ready_i (skid_ready)
    );

    rename_map_table i_map_table (
        .reset_i     (reset_i),
        .cpu_clock_i (cpu_clock_i),
        .rd_idx_i    (map_rd_idx),
        .rd_preg_o   (map_rd_preg),
        .wr_en_i     (map_wr_en),
        .wr_idx_i    (map_wr_idx),
        .wr_preg_i   (map_wr_preg)
    );

    rename_free_list i_free_list (
        .reset_i      (reset_i),
        .cpu_clock_i  (cpu_clock_i),
        .pop0_i       (pop0),
        .pop1_i       (pop1),
        .free_head0_o (free_head0),
        .free_head1_o (free_head1),
        .free_count_o (free_count),
        .commit_i     (commit_i)
    );

    rename_logic i_rename_logic (
        .reset_i        (reset_i),
        .cpu_clock_i    (cpu_clock_i),
        .bundle_i       (skid_bundle),
        .bundle_valid_i (skid_valid),
        .bundle_ready_o (skid_ready),
        .map_rd_idx_o   (map_rd_idx),
        .map_rd_preg_i  (map_rd_preg),
        .map_wr_en_o    (map_wr_en),
        .map_wr_idx_o   (map_wr_idx),
        .map_wr_preg_o  (map_wr_preg),
        .free_head0_i   (free_head0),
        .free_head1_i   (free_head1),
        .free_count_i   (free_count),
        .pop0_o         (pop0),
        .pop1_o         (pop1),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o),
        .packet_ready_i (packet_ready_i)
    );

endmodule

// ==== rename_logic.sv ====
`timescale 1ns/10ps
`include "rename_params.svh"

module rename_logic (
    input  logic                        reset_i,
    input  logic                        cpu_clock_i,
    input  rename_pkg::bundle_t         bundle_i,
    input  logic                        bundle_valid_i,
    output logic                        bundle_ready_o,
    output arch_pkg::areg_t       [5:0] map_rd_idx_o,
    input  rename_pkg::preg_t     [5:0] map_rd_preg_i,
    output logic                  [1:0] map_wr_en_o,
    output arch_pkg::areg_t       [1:0] map_wr_idx_o,
    output rename_pkg::preg_t     [1:0] map_wr_preg_o,
    input  rename_pkg::preg_t           free_head0_i,
    input  rename_pkg::preg_t           free_head1_i,
    input  logic [`RN_PREG_W-1:0]       free_count_i,
    output logic                        pop0_o,
    output logic                        pop1_o,
    output rename_pkg::packet_t         packet_o,
    output logic                        packet_valid_o,
    input  logic                        packet_ready_i
);

    localparam int CNT_W = `RN_PREG_W;

    arch_pkg::instr_t    ins0;
    arch_pkg::instr_t    ins1;
    logic                alloc0;
    logic                alloc1;
    logic [CNT_W-1:0]    need;
    logic                out_free;
    logic                accept;
    rename_pkg::preg_t   pdest0;
    rename_pkg::preg_t   pdest1;
    rename_pkg::preg_t   prs1_1;
    rename_pkg::preg_t   prs2_1;
    rename_pkg::preg_t   old0;
    rename_pkg::preg_t   old1;
    rename_pkg::packet_t packet_d;

    function automatic rename_pkg::renamed_t build_renamed(
        arch_pkg::instr_t  ins,
        rename_pkg::preg_t prs1,
        rename_pkg::preg_t prs2,
        rename_pkg::preg_t pdest,
        rename_pkg::preg_t old_pdest,
        logic              alloc
    );
        rename_pkg::renamed_t r;
        r.valid     = ins.valid;
        r.opcode    = ins.opcode;
        r.prs1      = prs1;
        r.prs2      = prs2;
        r.pdest     = pdest;
        r.old_pdest = old_pdest;
        r.allocated = alloc;
        return r;
    endfunction

    assign ins0 = bundle_i.ins0;
    assign ins1 = bundle_i.ins1;

    assign alloc0 = ins0.valid & ins0.writes_rd & (ins0.rd != '0);
    assign alloc1 = ins1.valid & ins1.writes_rd & (ins1.rd != '0);
    assign need   = CNT_W'(alloc0) + CNT_W'(alloc1);

    assign out_free       = ~packet_valid_o | packet_ready_i;
    assign bundle_ready_o = out_free & (free_count_i >= need);
    assign accept         = bundle_valid_i & bundle_ready_o;

    assign map_rd_idx_o[0] = ins0.rs1;
    assign map_rd_idx_o[1] = ins0.rs2;
    assign map_rd_idx_o[2] = ins1.rs1;
    assign map_rd_idx_o[3] = ins1.rs2;
    assign map_rd_idx_o[4] = ins0.rd;
    assign map_rd_idx_o[5] = ins1.rd;

    // ins1 takes whichever head ins0 leaves it
    assign pdest0 = alloc0 ? free_head0_i : '0;
    assign pdest1 = alloc1 ? (alloc0 ? free_head1_i : free_head0_i) : '0;

    // the map does not see ins0's write yet, so ins1 bypasses around it
    assign prs1_1 = (alloc0 && ins0.rd == ins1.rs1) ? pdest0 : map_rd_preg_i[2];
    assign prs2_1 = (alloc0 && ins0.rd == ins1.rs2) ? pdest0 : map_rd_preg_i[3];
    assign old0   = alloc0 ? map_rd_preg_i[4] : '0;
    assign old1   = alloc1 ? ((alloc0 && ins0.rd == ins1.rd) ? pdest0 : map_rd_preg_i[5]) : '0;

    assign map_wr_en_o[0]   = accept & alloc0;
    assign map_wr_idx_o[0]  = ins0.rd;
    assign map_wr_preg_o[0] = pdest0;
    assign map_wr_en_o[1]   = accept & alloc1;
    assign map_wr_idx_o[1]  = ins1.rd;
    assign map_wr_preg_o[1] = pdest1;

    assign pop0_o = accept & (alloc0 | alloc1);
    assign pop1_o = accept & alloc0 & alloc1;

    always_comb begin
        packet_d.ins0 = build_renamed(ins0, map_rd_preg_i[0], map_rd_preg_i[1],
                                      pdest0, old0, alloc0);
        packet_d.ins1 = build_renamed(ins1, prs1_1, prs2_1, pdest1, old1, alloc1);
    end

    always_ff @(posedge cpu_clock_i) begin
        if (accept) begin
            packet_o <= packet_d; // held while the issue side stalls
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            packet_valid_o <= 1'b0;
        end else if (accept) begin
            packet_valid_o <= 1'b1;
        end else if (packet_ready_i) begin
            packet_valid_o <= 1'b0;
        end
    end

endmodule

// ==== rename_free_list.sv ====
`timescale 1ns/10ps
`include "rename_params.svh"

module rename_free_list (
    input  logic                  reset_i,
    input  logic                  cpu_clock_i,
    input  logic                  pop0_i,
    input  logic                  pop1_i,
    output rename_pkg::preg_t     free_head0_o,
    output rename_pkg::preg_t     free_head1_o,
    output logic [`RN_PREG_W-1:0] free_count_o,
    input  rename_pkg::commit_t   commit_i
);

    localparam int PTR_W = $clog2(`RN_FREE_DEPTH);
    localparam int CNT_W = `RN_PREG_W;

    rename_pkg::preg_t     mem_q [`RN_FREE_DEPTH];
    rename_pkg::fl_state_e state_q;
    logic [PTR_W-1:0]      head_q;
    logic [PTR_W-1:0]      tail_q;
    logic [CNT_W-1:0]      count_q;
    logic [PTR_W-1:0]      head_next1;
    logic                  filling;
    logic                  push;
    rename_pkg::preg_t     fill_preg;

    assign filling   = (state_q == rename_pkg::FL_FILL);
    assign push      = ~filling & commit_i.valid;
    assign fill_preg = rename_pkg::preg_t'(`RN_ARCH_REGS) + rename_pkg::preg_t'(tail_q);

    assign head_next1   = head_q + PTR_W'(1);
    assign free_head0_o = mem_q[head_q];
    assign free_head1_o = mem_q[head_next1];
    assign free_count_o = count_q; // stays at zero for the whole fill

    always_ff @(posedge cpu_clock_i) begin
        if (filling) begin
            mem_q[tail_q] <= fill_preg;
        end else if (push) begin
            mem_q[tail_q] <= commit_i.preg;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            state_q <= rename_pkg::FL_FILL;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            case (state_q)
                rename_pkg::FL_FILL: begin
                    tail_q <= tail_q + PTR_W'(1);
                    // the tail wraps back onto the head when the last register goes in
                    if (tail_q == PTR_W'(`RN_FREE_DEPTH - 1)) begin
                        state_q <= rename_pkg::FL_RUN;
                        count_q <= CNT_W'(`RN_FREE_DEPTH);
                    end
                end
                rename_pkg::FL_RUN: begin
                    // pop1 only comes together with pop0
                    head_q  <= head_q + PTR_W'(pop0_i) + PTR_W'(pop1_i);
                    if (push) tail_q <= tail_q + PTR_W'(1);
                    count_q <= count_q + CNT_W'(push) - CNT_W'(pop0_i) - CNT_W'(pop1_i);
                end
                default: begin
                    state_q <= rename_pkg::FL_FILL;
                end
            endcase
        end
    end

endmodule

// ==== rename_map_table.sv ====
`timescale 1ns/10ps
`include "rename_params.svh"

module rename_map_table (
    input  logic                        reset_i,
    input  logic                        cpu_clock_i,
    input  arch_pkg::areg_t       [5:0] rd_idx_i,
    output rename_pkg::preg_t     [5:0] rd_preg_o,
    input  logic                  [1:0] wr_en_i,
    input  arch_pkg::areg_t       [1:0] wr_idx_i,
    input  rename_pkg::preg_t     [1:0] wr_preg_i
);

    rename_pkg::preg_t map_q [`RN_ARCH_REGS];

    // r0 is hardwired, whatever the table holds for it
    always_comb begin
        for (int k = 0; k < 6; k++) begin
            if (rd_idx_i[k] == '0) begin
                rd_preg_o[k] = '0;
            end else begin
                rd_preg_o[k] = map_q[rd_idx_i[k]];
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::preg_t'(i); // identity map out of reset
            end
        end else begin
            if (wr_en_i[0]) begin
                map_q[wr_idx_i[0]] <= wr_preg_i[0];
            end
            // the younger instruction of the bundle has the final say
            if (wr_en_i[1]) begin
                map_q[wr_idx_i[1]] <= wr_preg_i[1];
            end
        end
    end

endmodule

// ==== rename_skid_buffer.sv ====
`timescale 1ns/10ps

module rename_skid_buffer (
    input  logic                reset_i,
    input  logic                cpu_clock_i,
    input  rename_pkg::bundle_t in_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    output rename_pkg::bundle_t out_o,
    output logic                out_valid_o,
    input  logic                out_ready_i
);

    rename_pkg::bundle_t mem_q [2];
    logic                rd_ptr_q;
    logic                wr_ptr_q;
    logic [1:0]          count_q;
    logic [1:0]          count_d;
    logic                empty;
    logic                in_fire;
    logic                push;
    logic                pop;

    assign empty   = (count_q == 2'd0);
    assign in_fire = in_valid_i & in_ready_o;

    // an empty buffer hands the input straight through
    assign out_o       = empty ? in_i : mem_q[rd_ptr_q];
    assign out_valid_o = empty ? in_fire : 1'b1;

    assign push = in_fire & ~(empty & out_ready_i); // bypassed bundles are not stored
    assign pop  = ~empty & out_ready_i;

    always_comb begin
        count_d = count_q;
        if (push & ~pop) begin
            count_d = count_q + 2'd1;
        end else if (pop & ~push) begin
            count_d = count_q - 2'd1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_i;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (reset_i) begin
            rd_ptr_q   <= 1'b0;
            wr_ptr_q   <= 1'b0;
            count_q    <= 2'd0;
            in_ready_o <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop) rd_ptr_q <= ~rd_ptr_q;
            count_q    <= count_d;
            in_ready_o <= (count_d != 2'd2); // ready is a flop, so it looks one cycle ahead
        end
    end

endmodule

// ==== rename_pkg.sv ====
`include "rename_params.svh"

package rename_pkg;

    typedef logic [`RN_PREG_W-1:0] preg_t;

    // ins0 is valid whenever the bundle is, ins1 has its own valid bit
    typedef struct packed {
        arch_pkg::instr_t ins1;
        arch_pkg::instr_t ins0;
    } bundle_t;

    typedef struct packed {
        logic              valid;
        arch_pkg::opcode_e opcode;
        preg_t             prs1;
        preg_t             prs2;
        preg_t             pdest;
        preg_t             old_pdest; // freed by the retire side at commit
        logic              allocated;
    } renamed_t;

    typedef struct packed {
        renamed_t ins1;
        renamed_t ins0;
    } packet_t;

    // a physical register handed back at commit
    typedef struct packed {
        logic  valid;
        preg_t preg;
    } commit_t;

    typedef enum logic {
        FL_FILL = 1'b0,
        FL_RUN  = 1'b1
    } fl_state_e;

endpackage

// ==== arch_pkg.sv ====
`include "rename_params.svh"

package arch_pkg;

    typedef logic [`RN_AREG_W-1:0] areg_t;

    // operation class, carried through rename untouched
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_SHIFT = 3'd5,
        OP_LOAD  = 3'd6,
        OP_STORE = 3'd7
    } opcode_e;

    // one decoded instruction as it leaves the decoder
    typedef struct packed {
        logic    valid;
        opcode_e opcode;
        areg_t   rs1;
        areg_t   rs2;
        areg_t   rd;
        logic    writes_rd; // rd is a real destination
    } instr_t;

endpackage

// ==== rename_params.svh ====
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// architectural register file of the ISA
`define RN_ARCH_REGS 32
`define RN_AREG_W 5

// physical register file behind the rename stage
`define RN_PHYS_REGS 64
`define RN_PREG_W 6

// registers that are not mapped after reset start out free
`define RN_FREE_DEPTH (`RN_PHYS_REGS - `RN_ARCH_REGS)

`endif
